// ==== hw/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  strb_t;

    localparam addr_t RESET_PC = 32'h0000_0000;

    // RV32I major opcodes in the kept subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_IMM,
        ALU_LINK
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_EQ,
        BR_NE,
        BR_LT
    } branch_kind_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK
    } ctrl_state_e;

    typedef struct packed {
        alu_op_e      alu_op;
        logic         use_imm;
        logic         reg_write;
        logic         is_load;
        logic         is_store;
        logic         byte_access;
        logic         load_unsigned;
        logic         is_branch;
        branch_kind_e branch_kind;
        logic         is_jump;
        logic         illegal;
    } ctrl_t;

endpackage

// ==== hw/mem_bus_if.sv ====
`timescale 1ns/10ps

interface mem_bus_if;

    logic             req;
    logic             we;
    core_pkg::addr_t  addr;
    core_pkg::strb_t  wstrb;
    core_pkg::word_t  wdata;
    core_pkg::word_t  rdata;
    logic             ack;

    modport master (
        output req, we, addr, wstrb, wdata,
        input  rdata, ack
    );

    modport port (
        input  req, we, addr, wstrb, wdata,
        output rdata, ack
    );

endinterface

// ==== hw/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
    input  core_pkg::word_t    inst,
    output core_pkg::reg_idx_t rs1,
    output core_pkg::reg_idx_t rs2,
    output core_pkg::reg_idx_t rd,
    output core_pkg::word_t    imm,
    output core_pkg::ctrl_t    ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_s;
    core_pkg::word_t imm_b;
    core_pkg::word_t imm_u;
    core_pkg::word_t imm_j;
    core_pkg::alu_op_e alu_f3;
    logic f3_ok;
    logic reg_ok;
    logic imm_ok;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Only 16 registers, so the top index bit is dropped
    assign rs1 = inst[18:15];
    assign rs2 = inst[23:20];
    assign rd  = inst[10:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Shared funct3 mapping for register and immediate ALU forms
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (opcode == core_pkg::OP_REG && funct7[5]) ?
                              core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  alu_f3 = core_pkg::ALU_SLL;
            3'b010:  alu_f3 = core_pkg::ALU_SLT;
            3'b100:  alu_f3 = core_pkg::ALU_XOR;
            3'b101:  alu_f3 = core_pkg::ALU_SRL;
            3'b110:  alu_f3 = core_pkg::ALU_OR;
            default: alu_f3 = core_pkg::ALU_AND;
        endcase
    end

    // sltu/sltiu and sra/srai are not part of the subset
    assign f3_ok  = funct3 != 3'b011;
    assign reg_ok = f3_ok && (funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 == 3'b000));
    assign imm_ok = f3_ok && (funct3[1:0] != 2'b01 || funct7 == 7'b0);

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            core_pkg::OP_LUI: begin
                imm            = imm_u;
                ctrl.alu_op    = core_pkg::ALU_PASS_IMM;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            core_pkg::OP_JAL: begin
                imm            = imm_j;
                ctrl.alu_op    = core_pkg::ALU_LINK;
                ctrl.reg_write = 1'b1;
                ctrl.is_jump   = 1'b1;
            end
            core_pkg::OP_BRANCH: begin
                imm            = imm_b;
                ctrl.is_branch = funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b100;
                ctrl.illegal   = !ctrl.is_branch;
                case (funct3)
                    3'b000:  ctrl.branch_kind = core_pkg::BR_EQ;
                    3'b001:  ctrl.branch_kind = core_pkg::BR_NE;
                    default: ctrl.branch_kind = core_pkg::BR_LT;
                endcase
            end
            core_pkg::OP_LOAD: begin
                imm                = imm_i;
                ctrl.use_imm       = 1'b1;
                ctrl.is_load       = funct3 == 3'b000 || funct3 == 3'b100 || funct3 == 3'b010;
                ctrl.reg_write     = ctrl.is_load;
                ctrl.illegal       = !ctrl.is_load;
                ctrl.byte_access   = funct3[1:0] == 2'b00;
                ctrl.load_unsigned = funct3[2];
            end
            core_pkg::OP_STORE: begin
                imm              = imm_s;
                ctrl.use_imm     = 1'b1;
                ctrl.is_store    = funct3 == 3'b000 || funct3 == 3'b010;
                ctrl.illegal     = !ctrl.is_store;
                ctrl.byte_access = funct3 == 3'b000;
            end
            core_pkg::OP_IMM: begin
                imm            = imm_i;
                ctrl.alu_op    = alu_f3;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = imm_ok;
                ctrl.illegal   = !imm_ok;
            end
            core_pkg::OP_REG: begin
                ctrl.alu_op    = alu_f3;
                ctrl.reg_write = reg_ok;
                ctrl.illegal   = !reg_ok;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps

module reg_file #(
    parameter int NUM_REGS = 16
) (
    input  logic               clock,
    input  logic               wen,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2
);

    core_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge clock) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired, whatever the array holds there
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // Decoder index width is fixed, so a smaller file can see out of range writes
    a_waddr_range: assert property (@(posedge clock) wen |-> waddr < NUM_REGS)
        else $error("reg_file write to x%0d beyond %0d registers", waddr, NUM_REGS);

endmodule

// ==== hw/alu_exec.sv ====
`timescale 1ns/10ps

module alu_exec (
    input  core_pkg::ctrl_t ctrl,
    input  core_pkg::addr_t pc,
    input  core_pkg::word_t rs1_d,
    input  core_pkg::word_t rs2_d,
    input  core_pkg::word_t imm,
    output core_pkg::word_t result,
    output logic            take_branch,
    output core_pkg::addr_t target
);

    core_pkg::word_t opb;
    logic br_cond;

    assign opb = ctrl.use_imm ? imm : rs2_d;

    // Loads and stores come through as add, giving rs1 plus imm
    always_comb begin
        case (ctrl.alu_op)
            core_pkg::ALU_SUB:      result = rs1_d - opb;
            core_pkg::ALU_AND:      result = rs1_d & opb;
            core_pkg::ALU_OR:       result = rs1_d | opb;
            core_pkg::ALU_XOR:      result = rs1_d ^ opb;
            core_pkg::ALU_SLT:      result = {31'b0, $signed(rs1_d) < $signed(opb)};
            core_pkg::ALU_SLL:      result = rs1_d << opb[4:0];
            core_pkg::ALU_SRL:      result = rs1_d >> opb[4:0];
            core_pkg::ALU_PASS_IMM: result = imm;
            core_pkg::ALU_LINK:     result = pc + 32'd4;
            default:                result = rs1_d + opb;
        endcase
    end

    always_comb begin
        case (ctrl.branch_kind)
            core_pkg::BR_EQ: br_cond = rs1_d == rs2_d;
            core_pkg::BR_NE: br_cond = rs1_d != rs2_d;
            default:         br_cond = $signed(rs1_d) < $signed(rs2_d);
        endcase
    end

    assign take_branch = ctrl.is_jump || (ctrl.is_branch && br_cond);
    assign target      = pc + imm;

endmodule

// ==== hw/lsu.sv ====
`timescale 1ns/10ps

module lsu (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            start,
    input  logic            is_fetch,
    input  core_pkg::ctrl_t ctrl,
    input  core_pkg::addr_t pc,
    input  core_pkg::addr_t addr,
    input  core_pkg::word_t store_data,
    output logic            done,
    output core_pkg::word_t inst,
    output core_pkg::word_t load_data,
    mem_bus_if.master       bus
);

    logic [7:0] lane_byte;

    // Request fields follow the sequencer, which holds them for the whole access
    assign bus.addr  = is_fetch ? pc : {addr[31:2], 2'b00};
    assign bus.we    = !is_fetch && ctrl.is_store;
    assign bus.wdata = ctrl.byte_access ? {4{store_data[7:0]}} : store_data;

    always_comb begin
        if (!bus.we) begin
            bus.wstrb = 4'b0000;
        end else if (ctrl.byte_access) begin
            bus.wstrb = 4'b0001 << addr[1:0];
        end else begin
            bus.wstrb = 4'b1111;
        end
    end

    assign done      = bus.req && bus.ack;
    assign lane_byte = bus.rdata[{addr[1:0], 3'b000} +: 8];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bus.req <= 1'b0;
        end else if (start) begin
            bus.req <= 1'b1;
        end else if (done) begin
            bus.req <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (done && is_fetch) begin
            inst <= bus.rdata;
        end
        if (done && !is_fetch) begin
            if (!ctrl.byte_access) begin
                load_data <= bus.rdata;
            end else if (ctrl.load_unsigned) begin
                load_data <= {24'b0, lane_byte};
            end else begin
                load_data <= {{24{lane_byte[7]}}, lane_byte};
            end
        end
    end

    // The sequencer waits for done before starting another access
    a_one_request: assert property (@(posedge clock) disable iff (!rst_n)
        start |-> !bus.req)
        else $error("lsu start while a request is outstanding");

    // Address and data come from the sequencer, decoder and register file
    a_req_stable: assert property (@(posedge clock) disable iff (!rst_n)
        bus.req && !bus.ack |=> $stable(bus.addr) && $stable(bus.wdata) && $stable(bus.we))
        else $error("lsu request changed while waiting for ack");

endmodule

// ==== hw/core_ctrl.sv ====
`timescale 1ns/10ps

module core_ctrl (
    input  logic            clock,
    input  logic            rst_n,
    input  core_pkg::ctrl_t ctrl,
    input  logic            take_branch,
    input  core_pkg::addr_t target,
    input  logic            lsu_done,
    output logic            lsu_start,
    output logic            is_fetch,
    output logic            reg_wen,
    output core_pkg::addr_t pc,
    output logic            retire
);

    core_pkg::ctrl_state_e state;
    logic boot;

    assign is_fetch = state == core_pkg::ST_FETCH;
    assign retire   = state == core_pkg::ST_WRITEBACK;
    assign reg_wen  = retire && ctrl.reg_write;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= core_pkg::ST_FETCH;
            pc        <= core_pkg::RESET_PC;
            lsu_start <= 1'b0;
            boot      <= 1'b1;
        end else begin
            lsu_start <= 1'b0;
            boot      <= 1'b0;
            case (state)
                core_pkg::ST_FETCH: begin
                    // first fetch after reset has no writeback to launch it
                    if (boot) begin
                        lsu_start <= 1'b1;
                    end
                    if (lsu_done) begin
                        state <= core_pkg::ST_EXECUTE;
                    end
                end
                core_pkg::ST_EXECUTE: begin
                    if (ctrl.is_load || ctrl.is_store) begin
                        state     <= core_pkg::ST_MEMORY;
                        lsu_start <= 1'b1;
                    end else begin
                        state <= core_pkg::ST_WRITEBACK;
                    end
                end
                core_pkg::ST_MEMORY: begin
                    if (lsu_done) begin
                        state <= core_pkg::ST_WRITEBACK;
                    end
                end
                default: begin
                    pc        <= take_branch ? target : pc + 32'd4;
                    state     <= core_pkg::ST_FETCH;
                    lsu_start <= 1'b1;
                end
            endcase
        end
    end

    // Decoder output is only meaningful once the fetched word is latched
    a_no_illegal: assert property (@(posedge clock) disable iff (!rst_n)
        state == core_pkg::ST_EXECUTE |-> !ctrl.illegal)
        else $error("illegal instruction at pc %h", pc);

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps

module rv_core #(
    parameter int NUM_REGS = 16
) (
    input  logic            clock,
    input  logic            rst_n,
    output logic            mem_req,
    output logic            mem_we,
    output core_pkg::addr_t mem_addr,
    output core_pkg::strb_t mem_wstrb,
    output core_pkg::word_t mem_wdata,
    input  core_pkg::word_t mem_rdata,
    input  logic            mem_ack,
    output core_pkg::addr_t pc,
    output logic            retire
);

    mem_bus_if bus ();

    core_pkg::word_t    inst;
    core_pkg::word_t    imm;
    core_pkg::word_t    rs1_d;
    core_pkg::word_t    rs2_d;
    core_pkg::word_t    alu_result;
    core_pkg::word_t    load_data;
    core_pkg::word_t    wb_data;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::reg_idx_t rd;
    core_pkg::ctrl_t    ctrl;
    core_pkg::addr_t    target;
    logic take_branch;
    logic lsu_start;
    logic lsu_done;
    logic is_fetch;
    logic reg_wen;

    assign mem_req   = bus.req;
    assign mem_we    = bus.we;
    assign mem_addr  = bus.addr;
    assign mem_wstrb = bus.wstrb;
    assign mem_wdata = bus.wdata;
    assign bus.rdata = mem_rdata;
    assign bus.ack   = mem_ack;

    assign wb_data = ctrl.is_load ? load_data : alu_result;

    inst_decoder u_inst_decoder (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm),
        .ctrl (ctrl)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clock  (clock),
        .wen    (reg_wen),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_d),
        .rdata2 (rs2_d)
    );

    alu_exec u_alu_exec (
        .ctrl        (ctrl),
        .pc          (pc),
        .rs1_d       (rs1_d),
        .rs2_d       (rs2_d),
        .imm         (imm),
        .result      (alu_result),
        .take_branch (take_branch),
        .target      (target)
    );

    lsu u_lsu (
        .clock      (clock),
        .rst_n      (rst_n),
        .start      (lsu_start),
        .is_fetch   (is_fetch),
        .ctrl       (ctrl),
        .pc         (pc),
        .addr       (alu_result),
        .store_data (rs2_d),
        .done       (lsu_done),
        .inst       (inst),
        .load_data  (load_data),
        .bus        (bus.master)
    );

    core_ctrl u_core_ctrl (
        .clock       (clock),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .take_branch (take_branch),
        .target      (target),
        .lsu_done    (lsu_done),
        .lsu_start   (lsu_start),
        .is_fetch    (is_fetch),
        .reg_wen     (reg_wen),
        .pc          (pc),
        .retire      (retire)
    );

endmodule

// ==== bench/tb_mem.sv ====
`timescale 1ns/10ps

module tb_mem (
    input  logic            clock,
    input  logic            req,
    input  logic            we,
    input  core_pkg::addr_t addr,
    input  core_pkg::strb_t wstrb,
    input  core_pkg::word_t wdata,
    output core_pkg::word_t rdata,
    output logic            ack
);

    // 1024 words, so only address bits 11:2 select a word
    core_pkg::word_t mem [1024];
    core_pkg::word_t read_word;
    int unsigned     max_idle;
    int unsigned     idle_left;
    logic            busy;
    logic            fire;

    initial begin
        rdata     = '0;
        ack       = 1'b0;
        read_word = '0;
        max_idle  = 0;
        idle_left = 0;
        busy      = 1'b0;
        fire      = 1'b0;
    end

    // Request sampled on the edge, answer driven 1 ns later
    always @(posedge clock) begin
        fire = 1'b0;
        if (!req) begin
            busy = 1'b0;
        end else if (!ack) begin
            if (!busy) begin
                busy      = 1'b1;
                idle_left = $urandom % (max_idle + 1);
            end
            if (idle_left == 0) begin
                fire = 1'b1;
                busy = 1'b0;
                if (we) begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (wstrb[lane]) begin
                            mem[addr[11:2]][8 * lane +: 8] = wdata[8 * lane +: 8];
                        end
                    end
                end
                read_word = mem[addr[11:2]];
            end else begin
                idle_left = idle_left - 1;
            end
        end
        #1;
        ack = fire;
        if (fire) begin
            rdata = read_word;
        end
    end

    task automatic set_latency(input int unsigned max_cycles);
        max_idle = max_cycles;
    endtask

    task automatic load_word(input core_pkg::addr_t byte_addr, input core_pkg::word_t value);
        mem[byte_addr[11:2]] = value;
    endtask

    task automatic peek_word(input core_pkg::addr_t byte_addr, output core_pkg::word_t value);
        value = mem[byte_addr[11:2]];
    endtask

endmodule

// ==== bench/tb_core.sv ====
`timescale 1ns/10ps

module tb_core;

    // About 150 instructions at no more than 40 cycles each
    localparam int CYCLE_LIMIT = 6000;
    localparam int DATA_BASE   = 'h400;

    logic            clock = 1'b0;
    logic            rst_n;
    logic            mem_req;
    logic            mem_we;
    core_pkg::addr_t mem_addr;
    core_pkg::strb_t mem_wstrb;
    core_pkg::word_t mem_wdata;
    core_pkg::word_t mem_rdata;
    logic            mem_ack;
    core_pkg::addr_t pc;
    logic            retire;
    int              cycles = 0;

    core_pkg::word_t prog [$];
    core_pkg::word_t expected [$];
    core_pkg::addr_t retired_pc [$];

    rv_core #(
        .NUM_REGS (16)
    ) u_rv_core (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wstrb (mem_wstrb),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack),
        .pc        (pc),
        .retire    (retire)
    );

    tb_mem u_mem (
        .clock (clock),
        .req   (mem_req),
        .we    (mem_we),
        .addr  (mem_addr),
        .wstrb (mem_wstrb),
        .wdata (mem_wdata),
        .rdata (mem_rdata),
        .ack   (mem_ack)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the core stopped retiring", cycles);
            $display("Checks failed");
            $fatal(1, "run aborted");
        end
    end

    // RV32I instruction formats
    function automatic core_pkg::word_t encode_r(input int f7, input int rs2, input int rs1,
                                                 input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic core_pkg::word_t encode_i(input int imm, input int rs1, input int f3,
                                                 input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic core_pkg::word_t encode_s(input int imm, input int rs2, input int rs1,
                                                 input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t encode_b(input int imm, input int rs2, input int rs1,
                                                 input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic core_pkg::word_t encode_u(input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic core_pkg::word_t encode_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic core_pkg::word_t fill_pattern(input core_pkg::addr_t addr);
        return {addr[15:0], ~addr[15:0]} ^ {addr[31:16], addr[31:16]};
    endfunction

    task automatic check_word(input core_pkg::word_t want, input core_pkg::word_t got,
                              input string what);
        if (got !== want) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, what, want, got);
            $display("Checks failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_pc(input core_pkg::addr_t want, input core_pkg::addr_t got,
                            input int index);
        if (got !== want) begin
            $display("mismatch at %0t: retire %0d pc expected %h got %h",
                     $time, index, want, got);
            $display("Checks failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic reset_core();
        @(posedge clock);
        #1;
        rst_n = 1'b0;
        repeat (16) @(posedge clock);
        prog.delete();
        expected.delete();
    endtask

    // Instruction writing x5, then sw x5 into the next result slot
    task automatic add_checked(input core_pkg::word_t inst, input core_pkg::word_t value);
        prog.push_back(inst);
        prog.push_back(encode_s(DATA_BASE + 4 * expected.size(), 5, 0, 2));
        expected.push_back(value);
    endtask

    task automatic run_program(input int count, input string tag);
        core_pkg::word_t value;
        for (int i = 0; i < prog.size(); i++) begin
            u_mem.load_word(4 * i, prog[i]);
        end
        // Idle loop after the program
        u_mem.load_word(4 * prog.size(), encode_j(0, 0));
        for (int i = 0; i < expected.size(); i++) begin
            u_mem.load_word(DATA_BASE + 4 * i, fill_pattern(DATA_BASE + 4 * i));
        end
        retired_pc.delete();
        @(posedge clock);
        #1;
        rst_n = 1'b1;
        while (retired_pc.size() < count) begin
            @(negedge clock);
            if (retire) begin
                retired_pc.push_back(pc);
            end
        end
        for (int i = 0; i < expected.size(); i++) begin
            u_mem.peek_word(DATA_BASE + 4 * i, value);
            check_word(expected[i], value, $sformatf("%s slot %0d", tag, i));
        end
    endtask

    task automatic test_alu_ops(input string tag);
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t c;
        a = 32'hFFFF_FFFB;
        b = 32'h1234_5678;
        c = 32'd3;
        reset_core();
        prog.push_back(encode_i(-5, 0, 0, 1, 'h13));
        prog.push_back(encode_u('h12345, 2));
        prog.push_back(encode_i('h678, 2, 0, 2, 'h13));
        prog.push_back(encode_i(3, 0, 0, 3, 'h13));
        prog.push_back(encode_i(31, 0, 0, 4, 'h13));
        add_checked(encode_r(0, 2, 1, 0, 5), a + b);
        add_checked(encode_r('h20, 1, 2, 0, 5), b - a);
        add_checked(encode_r(0, 2, 1, 7, 5), a & b);
        add_checked(encode_r(0, 2, 1, 6, 5), a | b);
        add_checked(encode_r(0, 2, 1, 4, 5), a ^ b);
        // -5 < 3 holds, 3 < -5 does not
        add_checked(encode_r(0, 3, 1, 2, 5), 32'd1);
        add_checked(encode_r(0, 1, 3, 2, 5), 32'd0);
        add_checked(encode_r(0, 4, 1, 1, 5), a << 31);
        add_checked(encode_r(0, 0, 2, 1, 5), b);
        add_checked(encode_r(0, 4, 1, 5, 5), a >> 31);
        add_checked(encode_r(0, 0, 1, 5, 5), a);
        add_checked(encode_i(-100, 1, 0, 5, 'h13), a - 32'd100);
        add_checked(encode_i('h0F0, 2, 7, 5, 'h13), b & 32'h0F0);
        add_checked(encode_i('h123, 1, 6, 5, 'h13), a | 32'h123);
        add_checked(encode_i(-1, 2, 4, 5, 'h13), ~b);
        // -5 < -4
        add_checked(encode_i(-4, 1, 2, 5, 'h13), 32'd1);
        add_checked(encode_i(31, 1, 1, 5, 'h13), a << 31);
        add_checked(encode_i(31, 1, 5, 5, 'h13), a >> 31);
        add_checked(encode_i(0, 2, 5, 5, 'h13), b);
        add_checked(encode_u('hFFFFF, 5), 32'hFFFF_F000);
        run_program(prog.size(), tag);
    endtask

    task automatic test_x0();
        reset_core();
        prog.push_back(encode_i(77, 0, 0, 0, 'h13));
        prog.push_back(encode_u('hABCDE, 0));
        // sw x0 over a nonzero fill
        prog.push_back(encode_s(DATA_BASE, 0, 0, 2));
        expected.push_back('0);
        add_checked(encode_i(5, 0, 0, 5, 'h13), 32'd5);
        add_checked(encode_r(0, 0, 0, 0, 5), 32'd0);
        run_program(prog.size(), "x0");
    endtask

    task automatic test_loads();
        core_pkg::word_t stored;
        logic [7:0]      lane_byte;
        stored = 32'h40FF_7F81;
        reset_core();
        u_mem.load_word('h500, stored);
        add_checked(encode_i('h500, 0, 2, 5, 'h03), stored);
        for (int lane = 0; lane < 4; lane++) begin
            lane_byte = stored[8 * lane +: 8];
            add_checked(encode_i('h500 + lane, 0, 0, 5, 'h03), {{24{lane_byte[7]}}, lane_byte});
            add_checked(encode_i('h500 + lane, 0, 4, 5, 'h03), {24'b0, lane_byte});
        end
        run_program(prog.size(), "loads");
    endtask

    task automatic test_byte_stores();
        core_pkg::addr_t base;
        core_pkg::word_t value;
        core_pkg::word_t want;
        reset_core();
        prog.push_back(encode_i('h1AB, 0, 0, 5, 'h13));
        for (int lane = 0; lane < 4; lane++) begin
            base = 'h600 + 4 * lane;
            u_mem.load_word(base, fill_pattern(base));
            prog.push_back(encode_s(base + lane, 5, 0, 0));
        end
        run_program(prog.size(), "sb");
        for (int lane = 0; lane < 4; lane++) begin
            base = 'h600 + 4 * lane;
            want = fill_pattern(base);
            want[8 * lane +: 8] = 8'hAB;
            u_mem.peek_word(base, value);
            check_word(want, value, $sformatf("sb lane %0d", lane));
        end
    endtask

    task automatic test_control_flow();
        core_pkg::addr_t want_pc [12] = '{32'h00, 32'h04, 32'h08, 32'h0C, 32'h14, 32'h1C,
                                          32'h20, 32'h28, 32'h2C, 32'h38, 32'h3C, 32'h44};
        core_pkg::word_t skip;
        skip = encode_i(99, 0, 0, 3, 'h13);
        reset_core();
        prog.push_back(encode_i(1, 0, 0, 1, 'h13));
        prog.push_back(encode_i(-2, 0, 0, 2, 'h13));
        prog.push_back(encode_b(8, 2, 1, 0));
        prog.push_back(encode_b(8, 2, 1, 1));
        prog.push_back(skip);
        // blt x2, x1 is taken since -2 < 1
        prog.push_back(encode_b(8, 1, 2, 4));
        prog.push_back(skip);
        prog.push_back(encode_b(8, 2, 1, 4));
        prog.push_back(encode_b(8, 1, 1, 0));
        prog.push_back(skip);
        prog.push_back(encode_b(8, 1, 1, 1));
        prog.push_back(encode_j(12, 7));
        prog.push_back(skip);
        prog.push_back(skip);
        prog.push_back(encode_s(DATA_BASE, 7, 0, 2));
        expected.push_back(32'h30);
        prog.push_back(encode_j(8, 0));
        prog.push_back(skip);
        run_program(12, "branch");
        for (int i = 0; i < 12; i++) begin
            check_pc(want_pc[i], retired_pc[i], i);
        end
    endtask

    initial begin
        void'($urandom(32'h30b0));
        rst_n = 1'b0;
        test_alu_ops("alu");
        test_x0();
        test_loads();
        test_byte_stores();
        test_control_flow();
        u_mem.set_latency(3);
        test_alu_ops("alu random latency");
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/core_pkg.sv
hw/mem_bus_if.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu_exec.sv
hw/lsu.sv
hw/core_ctrl.sv
hw/rv_core.sv
bench/tb_mem.sv
bench/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f vlog.f \
    && ./obj_dir/Vtb_core > sim.log 2>&1 \
    || echo "Simulation build or run returned an error" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || grep -q "All checks passed" sim.log || exit 1
